// File: rtl/ahb_settings.svh
/*
  Global sizing for the AHB-Lite subsystem.
  Included by every RTL file that needs bus widths or slave count.
*/
`ifndef AHB_SETTINGS_SVH
`define AHB_SETTINGS_SVH

`define AHB_NB_SLAVES  4
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32
`define AHB_MEM_WORDS  64
`define AHB_IDX_WIDTH  2
// Slave i gets base + i wait states
`define AHB_WAIT_BASE  0

`endif

// File: rtl/ahb_pkg.sv
/*
  Shared AHB-Lite types for the interconnect and its slaves.
  Transfer and response encodings follow the AMBA AHB-Lite values.
*/
package ahb_pkg;

  // Master transfer type
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Slave response, AHB-Lite only uses one bit
  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

  // Memory slave, waiting or not
  typedef enum logic {
    SLV_IDLE = 1'b0,
    SLV_WAIT = 1'b1
  } slave_state_e;

  // Default slave, first ERROR cycle pending
  typedef enum logic {
    ERR_IDLE  = 1'b0,
    ERR_FIRST = 1'b1
  } err_state_e;

endpackage

// File: rtl/ahb_bus_if.sv
/*
  One node-to-slave AHB-Lite link.
  The node drives the address phase and hready, the slave answers.
  Instantiated as an array, one entry per slave.
*/
`include "ahb_settings.svh"

interface ahb_bus_if;
  import ahb_pkg::*;

  // Address phase, driven by the node
  logic                       hsel;
  logic [`AHB_ADDR_WIDTH-1:0] haddr;
  logic                       hwrite;
  htrans_e                    htrans;
  // Write data, valid in the data phase
  logic [`AHB_DATA_WIDTH-1:0] hwdata;
  // Bus-wide ready seen by the slave
  logic                       hready;

  // Slave response
  logic [`AHB_DATA_WIDTH-1:0] hrdata;
  logic                       hreadyout;
  hresp_e                     hresp;

  modport node (
    output hsel,
    output haddr,
    output hwrite,
    output htrans,
    output hwdata,
    output hready,
    input  hrdata,
    input  hreadyout,
    input  hresp
  );

  modport slave (
    input  hsel,
    input  haddr,
    input  hwrite,
    input  htrans,
    input  hwdata,
    input  hready,
    output hrdata,
    output hreadyout,
    output hresp
  );

endinterface

// File: rtl/ahb_addr_map.sv
/*
  Slave region table for the AHB node.
  One inclusive start/end pair and valid bit per slave, written by strobe.
  A write is visible on the outputs in the next cycle.
*/
`include "ahb_settings.svh"

module ahb_addr_map (
  input  logic                                            hclk,
  input  logic                                            reset_i,
  // Configuration write port
  input  logic                                            cfg_we_i,
  input  logic [`AHB_IDX_WIDTH-1:0]                       cfg_idx_i,
  input  logic [`AHB_ADDR_WIDTH-1:0]                      cfg_start_i,
  input  logic [`AHB_ADDR_WIDTH-1:0]                      cfg_end_i,
  input  logic                                            cfg_valid_i,
  // Table contents towards the node
  output logic [`AHB_NB_SLAVES-1:0][`AHB_ADDR_WIDTH-1:0]  region_start_o,
  output logic [`AHB_NB_SLAVES-1:0][`AHB_ADDR_WIDTH-1:0]  region_end_o,
  output logic [`AHB_NB_SLAVES-1:0]                       region_valid_o
);

  // Valid bits, cleared so everything starts unmapped
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      region_valid_o <= '0;
    end else if (cfg_we_i) begin
      region_valid_o[cfg_idx_i] <= cfg_valid_i;
    end
  end

  // Bounds, only meaningful once valid
  always_ff @(posedge hclk) begin
    if (cfg_we_i) begin
      region_start_o[cfg_idx_i] <= cfg_start_i;
      region_end_o[cfg_idx_i]   <= cfg_end_i;
    end
  end

  // Any live region must be non-empty
  for (genvar i = 0; i < `AHB_NB_SLAVES; i++) begin : g_chk
    assert property (@(posedge hclk) disable iff (reset_i)
      region_valid_o[i] |-> region_start_o[i] <= region_end_o[i]);
  end

endmodule

// File: rtl/ahb_node.sv
/*
  AHB-Lite node for one master and several slaves.
  Decodes the address phase against the region table, keeps the target
  for the data phase and muxes the response back to the master.
  Unmapped active transfers are answered by an internal ERROR slave.
*/
`include "ahb_settings.svh"

module ahb_node (
  input  logic                                            hclk,
  input  logic                                            reset_i,
  // Master side
  input  logic [`AHB_ADDR_WIDTH-1:0]                      haddr_i,
  input  logic                                            hwrite_i,
  input  ahb_pkg::htrans_e                                htrans_i,
  input  logic [`AHB_DATA_WIDTH-1:0]                      hwdata_i,
  output logic [`AHB_DATA_WIDTH-1:0]                      hrdata_o,
  output logic                                            hready_o,
  output ahb_pkg::hresp_e                                 hresp_o,
  // Region table
  input  logic [`AHB_NB_SLAVES-1:0][`AHB_ADDR_WIDTH-1:0]  region_start_i,
  input  logic [`AHB_NB_SLAVES-1:0][`AHB_ADDR_WIDTH-1:0]  region_end_i,
  input  logic [`AHB_NB_SLAVES-1:0]                       region_valid_i,
  // Slave links
  ahb_bus_if.node                                         slv_o [`AHB_NB_SLAVES]
);
  import ahb_pkg::*;

  logic [`AHB_NB_SLAVES-1:0]                      hit;
  logic [`AHB_NB_SLAVES-1:0]                      hsel;
  logic                                           active;
  logic                                           miss;
  logic [`AHB_IDX_WIDTH-1:0]                      sel_idx;

  // Data-phase target
  logic                                           dp_active_q;
  logic                                           dp_miss_q;
  logic [`AHB_IDX_WIDTH-1:0]                      dp_idx_q;
  err_state_e                                     err_state_q;

  // Slave responses gathered into plain arrays
  logic [`AHB_NB_SLAVES-1:0]                      slv_hreadyout;
  logic [`AHB_NB_SLAVES-1:0][`AHB_DATA_WIDTH-1:0] slv_hrdata;
  hresp_e                                         slv_hresp [`AHB_NB_SLAVES];

  // BUSY and IDLE never select a slave
  assign active = (htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ);

  for (genvar i = 0; i < `AHB_NB_SLAVES; i++) begin : g_slv
    // Inclusive range compare
    assign hit[i] = region_valid_i[i] &&
                    (haddr_i >= region_start_i[i]) &&
                    (haddr_i <= region_end_i[i]);
    assign hsel[i] = active && !miss && (sel_idx == `AHB_IDX_WIDTH'(i));

    // Address phase is shared and only hsel differs
    assign slv_o[i].hsel   = hsel[i];
    assign slv_o[i].haddr  = haddr_i;
    assign slv_o[i].hwrite = hwrite_i;
    assign slv_o[i].htrans = htrans_i;
    assign slv_o[i].hwdata = hwdata_i;
    assign slv_o[i].hready = hready_o;

    assign slv_hreadyout[i] = slv_o[i].hreadyout;
    assign slv_hrdata[i]    = slv_o[i].hrdata;
    assign slv_hresp[i]     = slv_o[i].hresp;
  end

  // Walk downwards so the lowest matching index wins on overlap
  always_comb begin
    sel_idx = '0;
    miss    = 1'b1;
    for (int i = `AHB_NB_SLAVES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel_idx = `AHB_IDX_WIDTH'(i);
        miss    = 1'b0;
      end
    end
  end

  // Target latched only when the address phase is accepted
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      dp_active_q <= 1'b0;
      dp_miss_q   <= 1'b0;
      dp_idx_q    <= '0;
    end else if (hready_o) begin
      dp_active_q <= active && !miss;
      dp_miss_q   <= active && miss;
      dp_idx_q    <= sel_idx;
    end
  end

  // Default slave
  // First ERROR cycle stalls and the second one completes
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      err_state_q <= ERR_IDLE;
    end else if (err_state_q == ERR_FIRST) begin
      err_state_q <= ERR_IDLE;
    end else if (hready_o && active && miss) begin
      err_state_q <= ERR_FIRST;
    end
  end

  // Response mux
  always_comb begin
    hrdata_o = slv_hrdata[dp_idx_q];
    if (dp_miss_q) begin
      hready_o = (err_state_q != ERR_FIRST);
      hresp_o  = HRESP_ERROR;
    end else if (dp_active_q) begin
      hready_o = slv_hreadyout[dp_idx_q];
      hresp_o  = slv_hresp[dp_idx_q];
    end else begin
      // No data phase pending
      hready_o = 1'b1;
      hresp_o  = HRESP_OKAY;
    end
  end

  // Only the slave owning the data phase may stall
  assert property (@(posedge hclk) disable iff (reset_i) $onehot0(~slv_hreadyout));

  // Unmapped access gives exactly the two-cycle ERROR sequence
  assert property (@(posedge hclk) disable iff (reset_i)
    hready_o && active && miss
    |=> !hready_o && (hresp_o == HRESP_ERROR)
    ##1 hready_o && (hresp_o == HRESP_ERROR));

endmodule

// File: rtl/ahb_mem_slave.sv
/*
  AHB-Lite word memory slave.
  Inserts WAIT_STATES low hreadyout cycles before each data phase ends.
  Word offset wraps on the memory depth, response is always OKAY.
*/
`include "ahb_settings.svh"

module ahb_mem_slave #(
  parameter int WAIT_STATES = 0
) (
  input  logic      hclk,
  input  logic      reset_i,
  ahb_bus_if.slave  bus
);
  import ahb_pkg::*;

  localparam int MEM_AW = $clog2(`AHB_MEM_WORDS);
  localparam int CNT_W  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [`AHB_DATA_WIDTH-1:0] mem [`AHB_MEM_WORDS];

  slave_state_e               state_q;
  logic [CNT_W-1:0]           cnt_q;
  logic                       pend_q;
  logic [MEM_AW-1:0]          addr_q;
  logic                       write_q;
  logic                       accept;

  // Address phase for us
  assign accept = bus.hsel && bus.hready &&
                  ((bus.htrans == HTRANS_NONSEQ) || (bus.htrans == HTRANS_SEQ));

  // Done once the wait counter has drained
  assign bus.hreadyout = (cnt_q == '0);
  assign bus.hresp     = HRESP_OKAY;
  // Async read of the latched word
  assign bus.hrdata    = mem[addr_q];

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      state_q <= SLV_IDLE;
      cnt_q   <= '0;
      pend_q  <= 1'b0;
    end else if (bus.hreadyout) begin
      // Previous data phase ends here, next may start
      pend_q <= accept;
      if (accept && (WAIT_STATES > 0)) begin
        state_q <= SLV_WAIT;
        cnt_q   <= CNT_W'(WAIT_STATES);
      end
    end else begin
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == CNT_W'(1)) begin
        state_q <= SLV_IDLE;
      end
    end
  end

  // Address and direction of the pending transfer
  always_ff @(posedge hclk) begin
    if (bus.hreadyout && accept) begin
      addr_q  <= bus.haddr[MEM_AW+1:2];
      write_q <= bus.hwrite;
    end
  end

  // Write lands on the last data-phase cycle
  always_ff @(posedge hclk) begin
    if (pend_q && write_q && bus.hreadyout) begin
      mem[addr_q] <= bus.hwdata;
    end
  end

  assert property (@(posedge hclk) disable iff (reset_i)
    (state_q == SLV_IDLE) |-> bus.hreadyout);

endmodule

// File: rtl/ahb_subsys_top.sv
/*
  AHB-Lite subsystem with one master port and a row of memory slaves.
  The region table is loaded through the cfg_* port before use.
*/
`include "ahb_settings.svh"

module ahb_subsys_top (
  input  logic                        hclk,
  input  logic                        reset_i,
  // Master port
  input  logic [`AHB_ADDR_WIDTH-1:0]  haddr_i,
  input  logic                        hwrite_i,
  input  ahb_pkg::htrans_e            htrans_i,
  input  logic [`AHB_DATA_WIDTH-1:0]  hwdata_i,
  output logic [`AHB_DATA_WIDTH-1:0]  hrdata_o,
  output logic                        hready_o,
  output ahb_pkg::hresp_e             hresp_o,
  // Region table write port
  input  logic                        cfg_we_i,
  input  logic [`AHB_IDX_WIDTH-1:0]   cfg_idx_i,
  input  logic [`AHB_ADDR_WIDTH-1:0]  cfg_start_i,
  input  logic [`AHB_ADDR_WIDTH-1:0]  cfg_end_i,
  input  logic                        cfg_valid_i
);

  logic [`AHB_NB_SLAVES-1:0][`AHB_ADDR_WIDTH-1:0] region_start;
  logic [`AHB_NB_SLAVES-1:0][`AHB_ADDR_WIDTH-1:0] region_end;
  logic [`AHB_NB_SLAVES-1:0]                      region_valid;

  ahb_bus_if slv_bus [`AHB_NB_SLAVES] ();

  ahb_addr_map addr_map_u0 (
    .hclk           (hclk),
    .reset_i        (reset_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_idx_i      (cfg_idx_i),
    .cfg_start_i    (cfg_start_i),
    .cfg_end_i      (cfg_end_i),
    .cfg_valid_i    (cfg_valid_i),
    .region_start_o (region_start),
    .region_end_o   (region_end),
    .region_valid_o (region_valid)
  );

  ahb_node node_u0 (
    .hclk           (hclk),
    .reset_i        (reset_i),
    .haddr_i        (haddr_i),
    .hwrite_i       (hwrite_i),
    .htrans_i       (htrans_i),
    .hwdata_i       (hwdata_i),
    .hrdata_o       (hrdata_o),
    .hready_o       (hready_o),
    .hresp_o        (hresp_o),
    .region_start_i (region_start),
    .region_end_i   (region_end),
    .region_valid_i (region_valid),
    .slv_o          (slv_bus)
  );

  // Slave i is i wait states slower than the base
  for (genvar i = 0; i < `AHB_NB_SLAVES; i++) begin : g_mem
    ahb_mem_slave #(
      .WAIT_STATES (`AHB_WAIT_BASE + i)
    ) mem_slave_u (
      .hclk    (hclk),
      .reset_i (reset_i),
      .bus     (slv_bus[i])
    );
  end

endmodule

// File: bench/ahb_clock_gen.sv
/*
  Clock and reset source for the AHB testbench.
  Reset is held high for RESET_CYCLES rising edges, then released.
*/
module ahb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic hclk_o,
  output logic reset_o
);

  initial begin
    hclk_o = 1'b0;
    forever #(PERIOD / 2) hclk_o = ~hclk_o;
  end

  // Release just after a rising edge, away from the falling-edge drive
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge hclk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: bench/ahb_tb.sv
/*
  Directed testbench for the AHB-Lite subsystem.
  A reference memory per slave and a copy of the region table give the
  expected data, response and data-phase length of every transfer.
*/
`include "ahb_settings.svh"

module ahb_tb;
  import ahb_pkg::*;

  // About 200 cycles of traffic with a wide margin
  localparam int MAX_CYCLES = 3000;
  localparam int NB         = `AHB_NB_SLAVES;
  localparam int QMAX       = 16;

  logic                       hclk;
  logic                       reset;
  logic [`AHB_ADDR_WIDTH-1:0] haddr;
  logic                       hwrite;
  htrans_e                    htrans;
  logic [`AHB_DATA_WIDTH-1:0] hwdata;
  logic [`AHB_DATA_WIDTH-1:0] hrdata;
  logic                       hready;
  hresp_e                     hresp;
  logic                       cfg_we;
  logic [`AHB_IDX_WIDTH-1:0]  cfg_idx;
  logic [`AHB_ADDR_WIDTH-1:0] cfg_start;
  logic [`AHB_ADDR_WIDTH-1:0] cfg_end;
  logic                       cfg_valid;

  // Expected region table and memory contents
  logic [31:0] map_start [NB];
  logic [31:0] map_end   [NB];
  logic        map_valid [NB];
  logic [31:0] ref_mem   [NB][`AHB_MEM_WORDS];

  // Transfers waiting for the next pipelined run
  logic [31:0] q_addr  [QMAX];
  logic        q_write [QMAX];
  logic [31:0] q_wdata [QMAX];
  logic [31:0] q_exp   [QMAX];
  int          q_slave [QMAX];
  int          q_len;

  int          errors    = 0;
  int          checks    = 0;
  int          cycle_cnt = 0;
  logic [31:0] lcg_state = 32'd37550;

  ahb_clock_gen #(.PERIOD(10), .RESET_CYCLES(5)) clk_gen_u0 (
    .hclk_o  (hclk),
    .reset_o (reset)
  );

  ahb_subsys_top dut0 (
    .hclk (hclk), .reset_i (reset),
    .haddr_i (haddr), .hwrite_i (hwrite), .htrans_i (htrans), .hwdata_i (hwdata),
    .hrdata_o (hrdata), .hready_o (hready), .hresp_o (hresp),
    .cfg_we_i (cfg_we), .cfg_idx_i (cfg_idx), .cfg_start_i (cfg_start),
    .cfg_end_i (cfg_end), .cfg_valid_i (cfg_valid)
  );

  always @(posedge hclk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, transfers did not complete", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Lowest valid region containing the address or -1 when unmapped
  function automatic int decode(input logic [31:0] addr);
    int s;
    s = -1;
    for (int i = NB - 1; i >= 0; i--) begin
      if (map_valid[i] && addr >= map_start[i] && addr <= map_end[i]) s = i;
    end
    return s;
  endfunction

  function automatic logic [31:0] base_of(input int s);
    return 32'h0001_0000 * 32'(s + 1);
  endfunction

  function automatic logic [31:0] addr_of(input int s, input int w);
    return base_of(s) + 32'(4 * w);
  endfunction

  task automatic cfg_region(input int idx, input logic [31:0] start_a,
                            input logic [31:0] end_a, input logic valid);
    @(negedge hclk);
    cfg_we    = 1'b1;
    cfg_idx   = `AHB_IDX_WIDTH'(idx);
    cfg_start = start_a;
    cfg_end   = end_a;
    cfg_valid = valid;
    @(negedge hclk);
    cfg_we = 1'b0;
    map_start[idx] = start_a;
    map_end[idx]   = end_a;
    map_valid[idx] = valid;
  endtask

  // Expected read data taken from the model at queue time in bus order
  task automatic queue_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] data);
    int s;
    int w;
    s = decode(addr);
    w = int'((addr >> 2) % `AHB_MEM_WORDS);
    q_addr[q_len]  = addr;
    q_write[q_len] = wr;
    q_wdata[q_len] = data;
    q_slave[q_len] = s;
    if (s >= 0 && wr) ref_mem[s][w] = data;
    q_exp[q_len] = (s >= 0) ? ref_mem[s][w] : 32'h0;
    q_len++;
  endtask

  task automatic drive_addr(input int idx);
    haddr  = q_addr[idx];
    hwrite = q_write[idx];
    htrans = HTRANS_NONSEQ;
  endtask

  // Runs the queue with each address phase overlapping the previous data phase
  task automatic ahb_pipe();
    int   a_ph;
    int   d_ph;
    int   done;
    int   cyc;
    logic rdy;
    @(negedge hclk);
    while (!hready) @(negedge hclk);
    a_ph = 0;
    d_ph = -1;
    done = 0;
    cyc  = 0;
    drive_addr(0);
    while (done < q_len) begin
      // hready seen here decides the coming rising edge
      rdy = hready;
      if (d_ph >= 0) begin
        cyc++;
        check_value("hresp_o", 32'(hresp),
                    (q_slave[d_ph] >= 0) ? 32'(HRESP_OKAY) : 32'(HRESP_ERROR));
        if (rdy) begin
          check_value("data phase cycles", 32'(cyc),
                      (q_slave[d_ph] >= 0) ? 32'(q_slave[d_ph] + 1) : 32'd2);
          if (!q_write[d_ph] && q_slave[d_ph] >= 0) begin
            check_value("hrdata_o", hrdata, q_exp[d_ph]);
          end
          done++;
          cyc = 0;
        end
      end
      @(negedge hclk);
      if (rdy) begin
        d_ph   = a_ph;
        hwdata = (d_ph >= 0) ? q_wdata[d_ph] : 32'h0;
        if (a_ph >= 0 && a_ph + 1 < q_len) begin
          a_ph++;
          drive_addr(a_ph);
        end else begin
          a_ph   = -1;
          htrans = HTRANS_IDLE;
        end
      end
    end
    q_len = 0;
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
    queue_xfer(addr, 1'b1, data);
    ahb_pipe();
  endtask

  task automatic ahb_read(input logic [31:0] addr);
    queue_xfer(addr, 1'b0, 32'h0);
    ahb_pipe();
  endtask

  task automatic reset_defaults();
    check_value("hready_o", 32'(hready), 32'd1);
    check_value("hresp_o", 32'(hresp), 32'(HRESP_OKAY));
    // Nothing mapped yet so both get the two-cycle ERROR
    ahb_read(32'h0001_0000);
    ahb_read(32'h0000_0040);
  endtask

  task automatic mapped_rw();
    for (int s = 0; s < NB; s++) cfg_region(s, base_of(s), base_of(s) + 32'hFFF, 1'b1);
    for (int s = 0; s < NB; s++) begin
      for (int k = 0; k < 4; k++) ahb_write(addr_of(s, 3 * k), lcg_next());
    end
    for (int s = 0; s < NB; s++) begin
      for (int k = 0; k < 4; k++) ahb_read(addr_of(s, 3 * k));
    end
  endtask

  task automatic overlap_priority();
    logic [31:0] a;
    a = addr_of(3, 4);
    ahb_write(a, lcg_next());
    // Slave 2 shadows the first 256 bytes of slave 3
    cfg_region(2, base_of(3), base_of(3) + 32'hFF, 1'b1);
    ahb_write(a, lcg_next());
    ahb_read(a);
    cfg_region(2, base_of(3), base_of(3) + 32'hFF, 1'b0);
    ahb_read(a);
    cfg_region(2, base_of(3), base_of(3) + 32'hFF, 1'b1);
    ahb_read(a);
    cfg_region(2, base_of(2), base_of(2) + 32'hFFF, 1'b1);
  endtask

  task automatic back_to_back();
    queue_xfer(addr_of(3, 0), 1'b1, lcg_next());
    queue_xfer(addr_of(0, 3), 1'b0, 32'h0);
    queue_xfer(addr_of(1, 6), 1'b1, lcg_next());
    queue_xfer(addr_of(3, 0), 1'b0, 32'h0);
    queue_xfer(addr_of(2, 9), 1'b0, 32'h0);
    queue_xfer(addr_of(0, 0), 1'b1, lcg_next());
    queue_xfer(addr_of(0, 0), 1'b0, 32'h0);
    queue_xfer(addr_of(1, 6), 1'b0, 32'h0);
    ahb_pipe();
  endtask

  task automatic unmapped_in_seq();
    queue_xfer(addr_of(1, 3), 1'b1, lcg_next());
    // Same word offset as the checks below
    queue_xfer(32'h8000_000C, 1'b1, lcg_next());
    queue_xfer(addr_of(2, 3), 1'b0, 32'h0);
    queue_xfer(addr_of(0, 6), 1'b1, lcg_next());
    ahb_pipe();
    for (int s = 0; s < NB; s++) queue_xfer(addr_of(s, 3), 1'b0, 32'h0);
    ahb_pipe();
  endtask

  initial begin
    haddr     = '0;
    hwrite    = 1'b0;
    htrans    = HTRANS_IDLE;
    hwdata    = '0;
    cfg_we    = 1'b0;
    cfg_idx   = '0;
    cfg_start = '0;
    cfg_end   = '0;
    cfg_valid = 1'b0;
    q_len     = 0;
    for (int i = 0; i < NB; i++) map_valid[i] = 1'b0;
    @(negedge hclk);
    while (reset) @(negedge hclk);
    reset_defaults();
    mapped_rw();
    overlap_priority();
    back_to_back();
    unmapped_in_seq();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+rtl
rtl/ahb_pkg.sv
rtl/ahb_bus_if.sv
rtl/ahb_addr_map.sv
rtl/ahb_node.sv
rtl/ahb_mem_slave.sv
rtl/ahb_subsys_top.sv
bench/ahb_clock_gen.sv
bench/ahb_tb.sv

// File: Makefile
# Verilator build and run for the AHB-Lite subsystem testbench
VERILATOR ?= verilator
TOP       ?= ahb_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
